// ==== all.f ====
+incdir+.
ooo_pkg.sv
ooo_if.sv
register_file.sv
reorder_buffer.sv
issue_unit.sv
alu_unit.sv
ooo_core_top.sv
tb_ooo_core.sv

// ==== alu_unit.sv ====
`timescale 1ns/1ns
`include "ooo_macros.svh"

module alu_unit (
  input  logic                    clk_in,
  input  logic                    rst_in,
  input  logic                    flush_in,
  input  logic                    in_valid,
  input  logic [`OOO_XLEN-1:0]    a,
  input  logic [`OOO_XLEN-1:0]    b,
  input  logic [2:0]              funct3,
  input  logic                    sub,
  input  logic [`OOO_ROB_IXW-1:0] ix,
  output logic                    out_valid,
  output logic [`OOO_ROB_IXW-1:0] out_ix,
  output logic [`OOO_XLEN-1:0]    out_data
);

  // stage 1, operand register
  logic                    s1_valid;
  logic [`OOO_XLEN-1:0]    s1_a;
  logic [`OOO_XLEN-1:0]    s1_b;
  logic [2:0]              s1_f3;
  logic                    s1_sub;
  logic [`OOO_ROB_IXW-1:0] s1_ix;
  logic [`OOO_XLEN-1:0]    res;

  always_comb begin
    case (s1_f3)
      3'b000:  res = s1_sub ? (s1_a - s1_b) : (s1_a + s1_b);
      3'b100:  res = s1_a ^ s1_b;
      3'b110:  res = s1_a | s1_b;
      3'b111:  res = s1_a & s1_b;
      default: res = s1_a + s1_b; // unused encodings behave as add
    endcase
  end

  // valids, a flush kills both stages
  always_ff @(posedge clk_in) begin
    if (rst_in || flush_in) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      out_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk_in) begin
    s1_a     <= a;
    s1_b     <= b;
    s1_f3    <= funct3;
    s1_sub   <= sub;
    s1_ix    <= ix;
    out_ix   <= s1_ix; // stage 2, compute register
    out_data <= res;
  end

endmodule

// ==== issue_unit.sv ====
`timescale 1ns/1ns
`include "ooo_macros.svh"

module issue_unit (
  input  logic                    instr_valid,
  input  ooo_pkg::instr_word_u    instr,
  output logic                    stall,
  operand_read_if.reader          rd,
  // bypass lookup into the reorder buffer
  output logic [`OOO_ROB_IXW-1:0] byp_ix1,
  output logic [`OOO_ROB_IXW-1:0] byp_ix2,
  input  logic [`OOO_XLEN-1:0]    byp_data1,
  input  logic [`OOO_XLEN-1:0]    byp_data2,
  input  logic                    byp_done1,
  input  logic                    byp_done2,
  input  logic                    full,
  input  logic [`OOO_ROB_IXW-1:0] alloc_ix,
  input  logic                    flush_in,
  output logic                    dispatch,
  output logic [`OOO_REG_AW-1:0]  dispatch_rd,
  // towards the alu
  output logic                    alu_valid,
  output logic [`OOO_XLEN-1:0]    alu_a,
  output logic [`OOO_XLEN-1:0]    alu_b,
  output logic [2:0]              alu_funct3,
  output logic                    alu_sub,
  output logic [`OOO_ROB_IXW-1:0] alu_ix
);

  logic                 is_reg;   // R view
  logic                 is_imm;   // I view
  logic                 wait1;    // rs1 producer not done yet
  logic                 wait2;    // rs2 producer not done, R-form only
  logic [`OOO_XLEN-1:0] op1;
  logic [`OOO_XLEN-1:0] op2;
  logic [`OOO_XLEN-1:0] imm_sext;

  assign is_reg = (instr.r.opcode == `OOO_OPC_REG);
  assign is_imm = (instr.i.opcode == `OOO_OPC_IMM);

  // rs1 sits at the same bits in both layouts, rs2 only in R
  assign rd.rs1 = instr.i.rs1;
  assign rd.rs2 = instr.r.rs2;

  // buffer entry named by the rename tag
  assign byp_ix1 = rd.rob_ix1;
  assign byp_ix2 = rd.rob_ix2;

  // busy register reads come from the buffer instead of the file
  assign op1   = rd.busy1 ? byp_data1 : rd.rval1;
  assign op2   = rd.busy2 ? byp_data2 : rd.rval2;
  assign wait1 = rd.busy1 && !byp_done1;
  assign wait2 = is_reg && rd.busy2 && !byp_done2; // addi ignores rs2

  assign imm_sext = {{(`OOO_XLEN-12){instr.i.imm[11]}}, instr.i.imm};

  // full stalls regardless, operand waits only for a live word
  assign stall = full || (instr_valid && (wait1 || wait2));

  // other opcodes are consumed without effect
  assign dispatch    = instr_valid && (is_reg || is_imm) && !stall && !flush_in;
  assign dispatch_rd = instr.r.rd;

  assign alu_valid  = dispatch;
  assign alu_a      = op1;
  assign alu_b      = is_imm ? imm_sext : op2;
  assign alu_funct3 = is_imm ? 3'b000 : instr.r.funct3; // addi is a plain add
  assign alu_sub    = is_reg && instr.r.funct7[5];
  assign alu_ix     = alloc_ix; // result goes back to the slot just taken

endmodule

// ==== ooo_core_top.sv ====
`timescale 1ns/1ns
`include "ooo_macros.svh"

module ooo_core_top (
  input  logic                   clk_in,
  input  logic                   rst_in,
  input  logic                   instr_valid_in,
  input  logic [`OOO_XLEN-1:0]   instr_in,
  input  logic                   flush_in,
  output logic                   stall_out,
  output logic                   commit_valid_out,
  output logic [`OOO_REG_AW-1:0] commit_rd_out,
  output logic [`OOO_XLEN-1:0]   commit_data_out
);

  operand_read_if i_rd_if ();
  commit_if       i_cm_if ();

  logic                    dispatch;
  logic [`OOO_REG_AW-1:0]  dispatch_rd;
  logic [`OOO_ROB_IXW-1:0] alloc_ix;
  logic                    full;
  logic [`OOO_ROB_IXW-1:0] byp_ix1, byp_ix2;
  logic [`OOO_XLEN-1:0]    byp_data1, byp_data2;
  logic                    byp_done1, byp_done2;
  logic [`OOO_REG_AW-1:0]  flush_addrs [`OOO_ROB_DEPTH];
  // issue to alu
  logic                    alu_valid, alu_sub;
  logic [`OOO_XLEN-1:0]    alu_a, alu_b;
  logic [2:0]              alu_funct3;
  logic [`OOO_ROB_IXW-1:0] alu_ix;
  // alu back to the buffer
  logic                    cpl_valid;
  logic [`OOO_ROB_IXW-1:0] cpl_ix;
  logic [`OOO_XLEN-1:0]    cpl_data;

  issue_unit i_issue (
    .instr_valid(instr_valid_in), .instr(instr_in), .stall(stall_out), .rd(i_rd_if),
    .byp_ix1(byp_ix1), .byp_ix2(byp_ix2), .byp_data1(byp_data1), .byp_data2(byp_data2),
    .byp_done1(byp_done1), .byp_done2(byp_done2), .full(full), .alloc_ix(alloc_ix),
    .flush_in(flush_in), .dispatch(dispatch), .dispatch_rd(dispatch_rd),
    .alu_valid(alu_valid), .alu_a(alu_a), .alu_b(alu_b), .alu_funct3(alu_funct3),
    .alu_sub(alu_sub), .alu_ix(alu_ix)
  );

  register_file i_regfile (
    .clk_in(clk_in), .rst_in(rst_in), .rd(i_rd_if), .cm(i_cm_if),
    .issue(dispatch), .rob_ix(alloc_ix), .rd_in(dispatch_rd), // rename on dispatch
    .flush_in(flush_in), .flush_addrs(flush_addrs)
  );

  reorder_buffer i_rob (
    .clk_in(clk_in), .rst_in(rst_in), .flush_in(flush_in),
    .dispatch(dispatch), .dispatch_rd(dispatch_rd), .alloc_ix(alloc_ix), .full(full),
    .cpl_valid(cpl_valid), .cpl_ix(cpl_ix), .cpl_data(cpl_data),
    .byp_ix1(byp_ix1), .byp_ix2(byp_ix2), .byp_data1(byp_data1), .byp_data2(byp_data2),
    .byp_done1(byp_done1), .byp_done2(byp_done2), .flush_addrs(flush_addrs),
    .cm(i_cm_if), .commit_valid(commit_valid_out), .commit_rd(commit_rd_out),
    .commit_data(commit_data_out)
  );

  alu_unit i_alu (
    .clk_in(clk_in), .rst_in(rst_in), .flush_in(flush_in),
    .in_valid(alu_valid), .a(alu_a), .b(alu_b), .funct3(alu_funct3), .sub(alu_sub),
    .ix(alu_ix), .out_valid(cpl_valid), .out_ix(cpl_ix), .out_data(cpl_data)
  );

endmodule

// ==== ooo_if.sv ====
`timescale 1ns/1ns
`include "ooo_macros.svh"

// combinational operand lookup, issue side asks and the file answers
interface operand_read_if;
  logic [`OOO_REG_AW-1:0]  rs1;
  logic [`OOO_REG_AW-1:0]  rs2;
  logic [`OOO_XLEN-1:0]    rval1;   // architectural value
  logic [`OOO_XLEN-1:0]    rval2;
  logic [`OOO_ROB_IXW-1:0] rob_ix1; // rename tag, only meaningful while busy
  logic [`OOO_ROB_IXW-1:0] rob_ix2;
  logic                    busy1;   // a younger result is still in flight
  logic                    busy2;

  modport reader (
    output rs1, rs2,
    input  rval1, rval2, rob_ix1, rob_ix2, busy1, busy2
  );

  modport file (
    input  rs1, rs2,
    output rval1, rval2, rob_ix1, rob_ix2, busy1, busy2
  );
endinterface

// in-order retirement write into the architectural file
interface commit_if;
  logic                    we;      // one pulse per retired instruction
  logic [`OOO_REG_AW-1:0]  wa;
  logic [`OOO_XLEN-1:0]    wd;
  logic [`OOO_ROB_IXW-1:0] wrob_ix; // buffer slot that produced wd

  modport source (
    output we, wa, wd, wrob_ix
  );

  modport sink (
    input  we, wa, wd, wrob_ix
  );
endinterface

// ==== ooo_macros.svh ====
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// datapath and register addressing
`define OOO_XLEN 32
`define OOO_REG_AW 5

// reorder buffer geometry, index width must cover the depth
`define OOO_ROB_IXW 3
`define OOO_ROB_DEPTH 8

// major opcodes kept by this core
`define OOO_OPC_REG 7'b0110011 // add sub and or xor
`define OOO_OPC_IMM 7'b0010011 // addi

// cycles from alu issue to result
`define OOO_ALU_LAT 2

`endif

// ==== ooo_pkg.sv ====
`include "ooo_macros.svh"

package ooo_pkg;

  // register-register layout
  typedef struct packed {
    logic [6:0]             funct7; // bit 5 picks sub over add
    logic [`OOO_REG_AW-1:0] rs2;
    logic [`OOO_REG_AW-1:0] rs1;
    logic [2:0]             funct3;
    logic [`OOO_REG_AW-1:0] rd;
    logic [6:0]             opcode;
  } instr_r_t;

  // register-immediate layout, imm sits where funct7 and rs2 are
  typedef struct packed {
    logic [11:0]            imm; // sign bit is imm[11]
    logic [`OOO_REG_AW-1:0] rs1;
    logic [2:0]             funct3;
    logic [`OOO_REG_AW-1:0] rd;
    logic [6:0]             opcode;
  } instr_i_t;

  // one 32-bit word, two views of the same bits
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
  } instr_word_u;

endpackage

// ==== register_file.sv ====
`timescale 1ns/1ns
`include "ooo_macros.svh"

module register_file (
  input  logic                    clk_in,
  input  logic                    rst_in,
  operand_read_if.file            rd,
  commit_if.sink                  cm,
  input  logic                    issue,   // rename strobe from dispatch
  input  logic [`OOO_ROB_IXW-1:0] rob_ix,  // slot given to the new instruction
  input  logic [`OOO_REG_AW-1:0]  rd_in,   // its destination
  input  logic                    flush_in,
  input  logic [`OOO_REG_AW-1:0]  flush_addrs [`OOO_ROB_DEPTH]
);

  localparam int NREG = 1 << `OOO_REG_AW;

  logic [`OOO_XLEN-1:0]    regs [NREG];
  logic [`OOO_ROB_IXW-1:0] tags [NREG]; // newest producer of each register
  logic [NREG-1:0]         busy;        // set while that producer is uncommitted

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < NREG; i++) begin // all 32, x31 included
        regs[i] <= '0;
        tags[i] <= '0;
      end
      busy <= '0;
    end else if (flush_in) begin
      // every live destination is in the list, so no busy bit survives
      for (int j = 0; j < `OOO_ROB_DEPTH; j++) begin
        busy[flush_addrs[j]] <= 1'b0;
        tags[flush_addrs[j]] <= '0;
      end
    end else begin
      if (cm.we && (cm.wa != '0)) begin
        regs[cm.wa] <= cm.wd;
        // an older producer retiring must not clear a newer rename
        if (cm.wrob_ix == tags[cm.wa]) begin
          busy[cm.wa] <= 1'b0;
        end
      end
      // placed after the commit write so a same-register rename wins
      if (issue && (rd_in != '0)) begin
        tags[rd_in] <= rob_ix;
        busy[rd_in] <= 1'b1;
      end
    end
  end

  // read ports, x0 forced to zero and never busy
  always_comb begin
    rd.rval1   = (rd.rs1 == '0) ? '0 : regs[rd.rs1];
    rd.rval2   = (rd.rs2 == '0) ? '0 : regs[rd.rs2];
    rd.rob_ix1 = tags[rd.rs1];
    rd.rob_ix2 = tags[rd.rs2];
    rd.busy1   = busy[rd.rs1] && (rd.rs1 != '0);
    rd.busy2   = busy[rd.rs2] && (rd.rs2 != '0);
  end

endmodule

// ==== reorder_buffer.sv ====
`timescale 1ns/1ns
`include "ooo_macros.svh"

module reorder_buffer (
  input  logic                    clk_in,
  input  logic                    rst_in,
  input  logic                    flush_in,
  // allocation from issue
  input  logic                    dispatch,
  input  logic [`OOO_REG_AW-1:0]  dispatch_rd,
  output logic [`OOO_ROB_IXW-1:0] alloc_ix,
  output logic                    full,
  // completion from the alu
  input  logic                    cpl_valid,
  input  logic [`OOO_ROB_IXW-1:0] cpl_ix,
  input  logic [`OOO_XLEN-1:0]    cpl_data,
  // operand bypass by tag
  input  logic [`OOO_ROB_IXW-1:0] byp_ix1,
  input  logic [`OOO_ROB_IXW-1:0] byp_ix2,
  output logic [`OOO_XLEN-1:0]    byp_data1,
  output logic [`OOO_XLEN-1:0]    byp_data2,
  output logic                    byp_done1,
  output logic                    byp_done2,
  output logic [`OOO_REG_AW-1:0]  flush_addrs [`OOO_ROB_DEPTH],
  commit_if.source                cm,
  output logic                    commit_valid,
  output logic [`OOO_REG_AW-1:0]  commit_rd,
  output logic [`OOO_XLEN-1:0]    commit_data
);

  localparam int DEPTH = `OOO_ROB_DEPTH;

  logic [`OOO_ROB_IXW-1:0] head;  // oldest entry
  logic [`OOO_ROB_IXW-1:0] tail;  // next free entry
  logic [`OOO_ROB_IXW:0]   count; // one extra bit to hold DEPTH

  logic [DEPTH-1:0]       ent_valid;
  logic [DEPTH-1:0]       ent_done;
  logic [`OOO_REG_AW-1:0] ent_rd  [DEPTH];
  logic [`OOO_XLEN-1:0]   ent_val [DEPTH];

  logic fire; // head retires at the coming edge

  assign fire     = ent_valid[head] && ent_done[head] && !flush_in;
  assign full     = (count == DEPTH);
  assign alloc_ix = tail;

  // tag-indexed bypass, done means the value is already in the entry
  assign byp_data1 = ent_val[byp_ix1];
  assign byp_data2 = ent_val[byp_ix2];
  assign byp_done1 = ent_valid[byp_ix1] && ent_done[byp_ix1];
  assign byp_done2 = ent_valid[byp_ix2] && ent_done[byp_ix2];

  // destinations the register file has to unbusy on flush
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      flush_addrs[i] = ent_valid[i] ? ent_rd[i] : '0; // empty slot names x0
    end
  end

  // retirement write, combinational so the file updates on the same edge
  assign cm.we      = fire;
  assign cm.wa      = ent_rd[head];
  assign cm.wd      = ent_val[head];
  assign cm.wrob_ix = head;

  always_ff @(posedge clk_in) begin
    if (rst_in || flush_in) begin // flush empties everything in flight
      head         <= '0;
      tail         <= '0;
      count        <= '0;
      ent_valid    <= '0;
      ent_done     <= '0;
      commit_valid <= 1'b0;
    end else begin
      if (dispatch) begin
        ent_valid[tail] <= 1'b1;
        ent_done[tail]  <= 1'b0;
        tail            <= tail + 1'b1; // wraps at DEPTH
      end
      if (cpl_valid) begin
        ent_done[cpl_ix] <= 1'b1;
      end
      if (fire) begin
        ent_valid[head] <= 1'b0;
        ent_done[head]  <= 1'b0;
        head            <= head + 1'b1;
      end
      commit_valid <= fire; // registered one-cycle pulse
      case ({dispatch, fire})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // both or neither
      endcase
    end
  end

  // payload, qualified by the control above
  always_ff @(posedge clk_in) begin
    if (dispatch) begin
      ent_rd[tail] <= dispatch_rd;
    end
    if (cpl_valid) begin
      ent_val[cpl_ix] <= cpl_data;
    end
    if (fire) begin
      commit_rd   <= ent_rd[head];
      commit_data <= ent_val[head];
    end
  end

endmodule

// ==== tb_ooo_core.sv ====
`timescale 1ns/1ns
`include "ooo_macros.svh"

module tb_ooo_core;

  localparam int N_INIT  = 31; // one addi per register x1..x31
  localparam int N_RAND  = 40;
  localparam int N_CHAIN = 20;
  localparam int N_BURST = 24;
  localparam int N_ZERO  = 8;
  localparam int N_FLUSH = 22; // 6 before the flush, 16 after
  localparam int N_TOTAL = N_INIT + N_RAND + N_CHAIN + N_BURST + N_ZERO + N_FLUSH;
  localparam int TIMEOUT_CYCLES = 10 * N_TOTAL * (`OOO_ALU_LAT + 2) + 100;

  logic                   clk_in;
  logic                   rst_in;
  logic                   instr_valid_in;
  logic [`OOO_XLEN-1:0]   instr_in;
  logic                   flush_in;
  logic                   stall_out;
  logic                   commit_valid_out;
  logic [`OOO_REG_AW-1:0] commit_rd_out;
  logic [`OOO_XLEN-1:0]   commit_data_out;

  ooo_pkg::instr_word_u pending_q [$];                // accepted, not yet retired
  logic [`OOO_XLEN-1:0] model_regs [1 << `OOO_REG_AW]; // written by commits only
  logic [15:0]          lfsr_state;
  int                   value_errors = 0;
  int                   other_errors = 0;
  int                   commit_count = 0;
  int                   cycle_count  = 0;

  ooo_core_top i_dut (
    .clk_in(clk_in), .rst_in(rst_in), .instr_valid_in(instr_valid_in),
    .instr_in(instr_in), .flush_in(flush_in), .stall_out(stall_out),
    .commit_valid_out(commit_valid_out), .commit_rd_out(commit_rd_out),
    .commit_data_out(commit_data_out)
  );

  initial begin
    clk_in = 1'b0;
    forever #2 clk_in = ~clk_in; // 4 ns period
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_next(lfsr_state); // one step per bit
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [`OOO_REG_AW-1:0] rand_reg();
    logic [31:0] r;
    r = take_bits(`OOO_REG_AW);
    return r[`OOO_REG_AW-1:0];
  endfunction

  function automatic logic [`OOO_REG_AW-1:0] nz_reg(); // never x0
    logic [`OOO_REG_AW-1:0] r;
    r = rand_reg();
    return (r == '0) ? 5'd1 : r;
  endfunction

  function automatic logic [11:0] rand_imm();
    logic [31:0] r;
    r = take_bits(12); // top bit set gives a negative immediate
    return r[11:0];
  endfunction

  function automatic ooo_pkg::instr_word_u enc_r(input logic [6:0] f7,
      input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3,
      input logic [4:0] rd);
    ooo_pkg::instr_word_u w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = f3;
    w.r.rd     = rd;
    w.r.opcode = `OOO_OPC_REG;
    return w;
  endfunction

  function automatic ooo_pkg::instr_word_u enc_i(input logic [11:0] imm,
      input logic [4:0] rs1, input logic [4:0] rd);
    ooo_pkg::instr_word_u w;
    w.i.imm    = imm;
    w.i.rs1    = rs1;
    w.i.funct3 = 3'b000; // addi
    w.i.rd     = rd;
    w.i.opcode = `OOO_OPC_IMM;
    return w;
  endfunction

  function automatic ooo_pkg::instr_word_u make_op(input logic [4:0] rd,
      input logic [4:0] rs1, input logic [4:0] rs2);
    logic [31:0] sel;
    sel = take_bits(3);
    case (sel[2:0])
      3'd0:    return enc_r(7'b0000000, rs2, rs1, 3'b000, rd); // add
      3'd1:    return enc_r(7'b0100000, rs2, rs1, 3'b000, rd); // sub
      3'd2:    return enc_r(7'b0000000, rs2, rs1, 3'b100, rd); // xor
      3'd3:    return enc_r(7'b0000000, rs2, rs1, 3'b110, rd); // or
      3'd4:    return enc_r(7'b0000000, rs2, rs1, 3'b111, rd); // and
      default: return enc_i(rand_imm(), rs1, rd);              // addi gets 3 of 8
    endcase
  endfunction

  // RV32I semantics against the committed state
  function automatic logic [`OOO_XLEN-1:0] ref_result(input ooo_pkg::instr_word_u w);
    logic [`OOO_XLEN-1:0]        a;
    logic [`OOO_XLEN-1:0]        b;
    logic signed [`OOO_XLEN-1:0] imm_ext;
    a       = model_regs[w.r.rs1];
    b       = model_regs[w.r.rs2];
    imm_ext = $signed(w.i.imm);
    if (w.i.opcode == `OOO_OPC_IMM) return a + imm_ext;
    case ({w.r.funct7, w.r.funct3})
      10'b0000000_000: return a + b;
      10'b0100000_000: return a - b;
      10'b0000000_100: return a ^ b;
      10'b0000000_110: return a | b;
      10'b0000000_111: return a & b;
      default:         return 'x; // not generated
    endcase
  endfunction

  task automatic check_reg_addr(input string name, input logic [`OOO_REG_AW-1:0] got,
                                input logic [`OOO_REG_AW-1:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_word(input string name, input logic [`OOO_XLEN-1:0] got,
                            input logic [`OOO_XLEN-1:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      value_errors++;
    end
  endtask

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic send_instr(input ooo_pkg::instr_word_u w);
    bit accepted;
    accepted       = 1'b0;
    instr_in       = w;
    instr_valid_in = 1'b1;
    while (!accepted) begin
      #1; // stall is settled a ns before the rising edge
      if (!stall_out) begin
        accepted = 1'b1;
        pending_q.push_back(w);
      end
      @(negedge clk_in); // word held while stalled
    end
  endtask

  initial begin : compare_commits
    ooo_pkg::instr_word_u w;
    logic [`OOO_XLEN-1:0] exp_data;
    forever begin
      @(negedge clk_in); // commit outputs are registered, stable here
      if (commit_valid_out === 1'b1) begin
        if (pending_q.size() == 0) begin
          $display("commit pulse at %0t ns with no instruction outstanding", $time);
          other_errors++;
        end else begin
          w        = pending_q.pop_front();
          exp_data = ref_result(w);
          check_reg_addr("commit_rd_out", commit_rd_out, w.r.rd);
          check_word("commit_data_out", commit_data_out, exp_data);
          if (w.r.rd != '0) model_regs[w.r.rd] = exp_data; // x0 stays zero
          commit_count++;
        end
      end
    end
  end

  initial begin : watchdog
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_in);
      cycle_count++;
    end
    $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin : stimulus
    logic [`OOO_REG_AW-1:0] rd_sel;
    logic [`OOO_REG_AW-1:0] rs1_sel;
    logic [`OOO_REG_AW-1:0] rs2_sel;
    logic [`OOO_REG_AW-1:0] prev_rd;
    logic [31:0]            coin;
    rst_in         = 1'b1;
    instr_valid_in = 1'b0;
    instr_in       = '0;
    flush_in       = 1'b0;
    lfsr_state     = 16'd57;
    for (int i = 0; i < (1 << `OOO_REG_AW); i++) model_regs[i] = '0;
    repeat (4) @(negedge clk_in);
    rst_in = 1'b0;
    repeat (8) begin // idle after reset, no commits and no stall
      #1;
      check_flag("stall_out", stall_out, 1'b0);
      @(negedge clk_in);
    end
    rd_sel = 5'd1;
    repeat (N_INIT) begin // give every register a value, negatives too
      send_instr(enc_i(rand_imm(), 5'd0, rd_sel));
      rd_sel++;
    end
    repeat (N_RAND) begin
      rd_sel  = rand_reg();
      rs1_sel = rand_reg();
      rs2_sel = rand_reg();
      send_instr(make_op(rd_sel, rs1_sel, rs2_sel));
    end
    prev_rd = nz_reg();
    repeat (N_CHAIN) begin // each reads the one before it through the buffer
      rd_sel  = nz_reg();
      coin    = take_bits(1);
      rs2_sel = coin[0] ? prev_rd : rand_reg();
      send_instr(make_op(rd_sel, prev_rd, rs2_sel));
      prev_rd = rd_sel;
    end
    for (int k = 0; k < N_BURST; k++) begin
      // writes x16..x31, reads x1..x15, back to back with no operand stall
      rd_sel  = 5'd16 + 5'(k % 16);
      rs1_sel = nz_reg() & 5'h0f;
      rs2_sel = rand_reg() & 5'h0f;
      if (rs1_sel == '0) rs1_sel = 5'd1;
      if (rs2_sel == '0) rs2_sel = 5'd2;
      send_instr(make_op(rd_sel, rs1_sel, rs2_sel));
    end
    repeat (N_ZERO / 2) begin
      rs1_sel = rand_reg();
      rs2_sel = rand_reg();
      send_instr(make_op(5'd0, rs1_sel, rs2_sel)); // result is dropped
    end
    repeat (N_ZERO / 2) begin
      rd_sel = nz_reg();
      send_instr(make_op(rd_sel, 5'd0, 5'd0)); // x0 must still read 0
    end
    prev_rd = nz_reg();
    repeat (6) begin // in flight when the flush hits
      rd_sel = nz_reg();
      send_instr(make_op(rd_sel, prev_rd, prev_rd));
      prev_rd = rd_sel;
    end
    instr_valid_in = 1'b0;
    flush_in       = 1'b1;
    #1; // commits seen on this edge were real, checked already
    pending_q.delete();
    @(negedge clk_in);
    flush_in = 1'b0;
    #1;
    check_flag("stall_out", stall_out, 1'b0);
    @(negedge clk_in);
    repeat (N_FLUSH - 6) begin // reads now see only retired values
      rd_sel  = nz_reg();
      rs1_sel = rand_reg();
      coin    = take_bits(1);
      rs2_sel = coin[0] ? prev_rd : rand_reg();
      send_instr(make_op(rd_sel, rs1_sel, rs2_sel));
    end
    instr_valid_in = 1'b0;
    while (pending_q.size() != 0) @(negedge clk_in); // drain
    repeat (10) @(negedge clk_in); // any late pulse is a duplicate
    #1;
    check_flag("stall_out", stall_out, 1'b0);
    $display("%0d commits, %0d value errors, %0d other errors",
             commit_count, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
